//--- source/floppy_io_config.svh
`ifndef FLOPPY_IO_CONFIG_SVH
`define FLOPPY_IO_CONFIG_SVH

//////////////////////////////
// port window
//////////////////////////////

// start of the 256-byte i/o window on the cpu bus
`define IO_BASE 16'hE000

//////////////////////////////
// clock dividers
//////////////////////////////

// clocks per timer decrement, short for simulation
`define TICK_DIV 20

// clocks per uart bit
`define BAUD_DIV 8

// clocks per sck half period
`define SPI_DIV 2

`endif

//--- source/bus_pkg.sv
package bus_pkg;

	//////////////////////////////
	// cpu bus widths
	//////////////////////////////

	// full cpu address
	typedef logic [15:0] bus_addr_t;

	// one i/o port byte
	typedef logic [7:0] bus_data_t;

endpackage

//--- source/port_map_pkg.sv
package port_map_pkg;

	//////////////////////////////
	// window offsets
	//////////////////////////////

	typedef enum logic [7:0] {
		MMCA = 8'd0,
		SPDR = 8'd1,
		SPSR = 8'd2,
		TXD  = 8'd4,
		CTL  = 8'd6,
		TMR1 = 8'd7,
		TMR2 = 8'd8,
		LED  = 8'd16
	} port_t;

	//////////////////////////////
	// peripheral state machines
	//////////////////////////////

	// uart frame phases
	typedef enum logic [1:0] {
		UART_IDLE,
		UART_START,
		UART_DATA,
		UART_STOP
	} uart_state_t;

	typedef enum logic {
		SPI_IDLE,
		SPI_SHIFT
	} spi_state_t;

	// bit position within a byte
	typedef logic [2:0] bit_count_t;

endpackage

//--- source/io_bus_if.sv
`timescale 1ns/1ns

interface io_bus_if;
	import bus_pkg::*;
	import port_map_pkg::*;

	// offset inside the window
	port_t port;
	bus_data_t wdata;
	// write inside the window, already qualified by ce
	logic wr;
	logic sel_valid;

	modport master (
		output port, wdata, wr, sel_valid
	);

	modport peripheral (
		input port, wdata, wr, sel_valid
	);

endinterface

//--- source/io_port_decode.sv
`timescale 1ns/1ns

`include "floppy_io_config.svh"

module io_port_decode (
	input logic clk,
	input logic reset_n,
	input logic ce,
	input bus_pkg::bus_addr_t addr,
	input bus_pkg::bus_data_t wdata,
	input logic wr,
	io_bus_if.master bus,
	input bus_pkg::bus_data_t tmr1_q,
	input bus_pkg::bus_data_t tmr2_q,
	input bus_pkg::bus_data_t spi_data,
	input logic uart_busy,
	input logic spi_busy,
	output bus_pkg::bus_data_t rdata,
	output bus_pkg::bus_data_t leds,
	output logic sd_dat3
);
	import bus_pkg::*;
	import port_map_pkg::*;

	localparam bus_addr_t io_base = `IO_BASE;

	logic led_wr;
	logic mmca_wr;

	//////////////////////////////
	// window decode
	//////////////////////////////

	// upper byte picks the window, lower byte the port
	assign bus.sel_valid = (addr[15:8] == io_base[15:8]);
	assign bus.port = port_t'(addr[7:0]);
	assign bus.wdata = wdata;
	assign bus.wr = wr && ce && bus.sel_valid;

	assign led_wr = bus.wr && (bus.port == LED);
	assign mmca_wr = bus.wr && (bus.port == MMCA);

	//////////////////////////////
	// local registers
	//////////////////////////////

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			leds <= '0;
			// card deselected
			sd_dat3 <= 1'b1;
		end else begin
			if (led_wr) begin
				leds <= wdata;
			end
			if (mmca_wr) begin
				sd_dat3 <= wdata[0];
			end
		end
	end

	//////////////////////////////
	// read mux
	//////////////////////////////

	always_comb begin
		rdata = 8'hFF;
		if (bus.sel_valid) begin
			case (bus.port)
				TMR1: rdata = tmr1_q;
				TMR2: rdata = tmr2_q;
				SPDR: rdata = spi_data;
				SPSR: rdata = {7'b0, spi_busy};
				CTL: rdata = {7'b0, uart_busy};
				MMCA: rdata = {7'b0, sd_dat3};
				LED: rdata = leds;
				default: rdata = 8'hFF;
			endcase
		end
	end

	// timer and busy values from the peripherals are defined once out of reset
	read_sources_known: assert property (
		@(posedge clk) disable iff (!reset_n) !$isunknown({tmr1_q, tmr2_q, uart_busy, spi_busy})
	) else $error("unknown timer or busy value at the read mux");

endmodule

//--- source/tick_timer.sv
`timescale 1ns/1ns

`include "floppy_io_config.svh"

module tick_timer #(
	parameter port_map_pkg::port_t its_port = port_map_pkg::TMR1
) (
	input logic clk,
	input logic reset_n,
	io_bus_if.peripheral bus,
	output bus_pkg::bus_data_t q
);
	localparam int presc_w = $clog2(`TICK_DIV);
	localparam logic [presc_w-1:0] presc_last = presc_w'(`TICK_DIV - 1);

	logic [presc_w-1:0] presc;
	logic tick;
	logic load;

	assign load = bus.wr && (bus.port == its_port);
	assign tick = (presc == presc_last);

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			presc <= '0;
			q <= '0;
		end else if (load) begin
			// restart the prescaler so the first tick is a full period away
			presc <= '0;
			q <= bus.wdata;
		end else begin
			if (tick) begin
				presc <= '0;
			end else begin
				presc <= presc + 1'b1;
			end
			// hold at zero
			if (tick && q != 8'h00) begin
				q <= q - 1'b1;
			end
		end
	end

	// an expired timer stays expired until the cpu reloads it
	no_wrap: assert property (
		@(posedge clk) disable iff (!reset_n) (q == 8'h00 && !load) |=> (q == 8'h00)
	) else $error("timer wrapped below zero");

endmodule

//--- source/uart_tx_fsm.sv
`timescale 1ns/1ns

`include "floppy_io_config.svh"

module uart_tx_fsm (
	input logic clk,
	input logic reset_n,
	io_bus_if.peripheral bus,
	output logic txd,
	output logic busy
);
	import bus_pkg::*;
	import port_map_pkg::*;

	localparam int baud_w = $clog2(`BAUD_DIV);
	localparam logic [baud_w-1:0] baud_last = baud_w'(`BAUD_DIV - 1);

	uart_state_t state;
	logic [baud_w-1:0] baud_cnt;
	logic baud_tick;
	bit_count_t bit_idx;
	bit_count_t next_idx;
	bus_data_t tx_byte;
	logic start;

	// writes during a frame are dropped
	assign start = bus.wr && (bus.port == TXD) && (state == UART_IDLE);
	assign baud_tick = (baud_cnt == baud_last);
	assign next_idx = bit_idx + 3'd1;
	assign busy = (state != UART_IDLE);

	// byte held for the whole frame
	always_ff @(posedge clk) begin
		if (start) begin
			tx_byte <= bus.wdata;
		end
	end

	//////////////////////////////
	// frame sequencer
	//////////////////////////////

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= UART_IDLE;
			baud_cnt <= '0;
			bit_idx <= '0;
			txd <= 1'b1;
		end else begin
			// baud counter runs only inside a frame
			if (state == UART_IDLE || baud_tick) begin
				baud_cnt <= '0;
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end

			case (state)
				UART_IDLE: begin
					if (start) begin
						state <= UART_START;
						txd <= 1'b0;
					end
				end
				UART_START: begin
					if (baud_tick) begin
						state <= UART_DATA;
						bit_idx <= '0;
						txd <= tx_byte[0];
					end
				end
				UART_DATA: begin
					if (baud_tick) begin
						if (bit_idx == 3'd7) begin
							state <= UART_STOP;
							txd <= 1'b1;
						end else begin
							// lsb first
							bit_idx <= next_idx;
							txd <= tx_byte[next_idx];
						end
					end
				end
				UART_STOP: begin
					if (baud_tick) begin
						state <= UART_IDLE;
					end
				end
				default: state <= UART_IDLE;
			endcase
		end
	end

	line_idle_high: assert property (
		@(posedge clk) disable iff (!reset_n) (state == UART_IDLE) |-> txd
	) else $error("uart line low while idle");

endmodule

//--- source/spi_shifter.sv
`timescale 1ns/1ns

`include "floppy_io_config.svh"

module spi_shifter (
	input logic clk,
	input logic reset_n,
	io_bus_if.peripheral bus,
	input logic miso,
	output logic mosi,
	output logic sck,
	output bus_pkg::bus_data_t data,
	output logic busy
);
	import port_map_pkg::*;

	localparam int half_w = $clog2(`SPI_DIV);
	localparam logic [half_w-1:0] half_last = half_w'(`SPI_DIV - 1);

	spi_state_t state;
	logic [half_w-1:0] half_cnt;
	logic half_tick;
	bit_count_t bit_idx;
	logic start;

	assign start = bus.wr && (bus.port == SPDR) && (state == SPI_IDLE);
	assign half_tick = (half_cnt == half_last);
	assign busy = (state == SPI_SHIFT);

	// shift register, miso enters at the rising sck edge
	always_ff @(posedge clk) begin
		if (start) begin
			data <= bus.wdata;
		end else if (state == SPI_SHIFT && half_tick && !sck) begin
			data <= {data[6:0], miso};
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= SPI_IDLE;
			half_cnt <= '0;
			bit_idx <= '0;
			sck <= 1'b0;
			mosi <= 1'b0;
		end else begin
			if (state == SPI_IDLE || half_tick) begin
				half_cnt <= '0;
			end else begin
				half_cnt <= half_cnt + 1'b1;
			end

			case (state)
				SPI_IDLE: begin
					if (start) begin
						state <= SPI_SHIFT;
						bit_idx <= '0;
						// msb out before the first rising edge
						mosi <= bus.wdata[7];
					end
				end
				SPI_SHIFT: begin
					if (half_tick) begin
						sck <= !sck;
						// falling edge, next bit out
						if (sck) begin
							mosi <= data[7];
							if (bit_idx == 3'd7) begin
								state <= SPI_IDLE;
							end else begin
								bit_idx <= bit_idx + 3'd1;
							end
						end
					end
				end
				default: state <= SPI_IDLE;
			endcase
		end
	end

	sck_idle_low: assert property (
		@(posedge clk) disable iff (!reset_n) (state == SPI_IDLE) |-> !sck
	) else $error("sck high while spi idle");

endmodule

//--- source/floppy_io.sv
`timescale 1ns/1ns

module floppy_io (
	input logic clk,
	input logic reset_n,
	input logic ce,
	input bus_pkg::bus_addr_t addr,
	input bus_pkg::bus_data_t wdata,
	input logic wr,
	output bus_pkg::bus_data_t rdata,
	input logic sd_dat,
	output logic sd_dat3,
	output logic sd_cmd,
	output logic sd_clk,
	output logic uart_txd,
	output bus_pkg::bus_data_t leds
);
	import bus_pkg::*;
	import port_map_pkg::*;

	bus_data_t tmr1_q;
	bus_data_t tmr2_q;
	bus_data_t spi_data;
	logic uart_busy;
	logic spi_busy;

	io_bus_if bus ();

	//////////////////////////////
	// decoder and local ports
	//////////////////////////////

	io_port_decode u_decode (
		.clk(clk),
		.reset_n(reset_n),
		.ce(ce),
		.addr(addr),
		.wdata(wdata),
		.wr(wr),
		.bus(bus.master),
		.tmr1_q(tmr1_q),
		.tmr2_q(tmr2_q),
		.spi_data(spi_data),
		.uart_busy(uart_busy),
		.spi_busy(spi_busy),
		.rdata(rdata),
		.leds(leds),
		.sd_dat3(sd_dat3)
	);

	//////////////////////////////
	// peripherals
	//////////////////////////////

	tick_timer #(.its_port(TMR1)) u_tmr1 (
		.clk(clk),
		.reset_n(reset_n),
		.bus(bus.peripheral),
		.q(tmr1_q)
	);

	tick_timer #(.its_port(TMR2)) u_tmr2 (
		.clk(clk),
		.reset_n(reset_n),
		.bus(bus.peripheral),
		.q(tmr2_q)
	);

	uart_tx_fsm u_uart (
		.clk(clk),
		.reset_n(reset_n),
		.bus(bus.peripheral),
		.txd(uart_txd),
		.busy(uart_busy)
	);

	// sd card in spi mode, cmd line carries mosi
	spi_shifter u_spi (
		.clk(clk),
		.reset_n(reset_n),
		.bus(bus.peripheral),
		.miso(sd_dat),
		.mosi(sd_cmd),
		.sck(sd_clk),
		.data(spi_data),
		.busy(spi_busy)
	);

endmodule

//--- dv/floppy_io_tb.sv
`timescale 1ns/1ns

`include "floppy_io_config.svh"

module floppy_io_tb;
	import bus_pkg::*;
	import port_map_pkg::*;

	localparam int clk_period = 100;
	localparam int drive_skew = 10;

	logic clk;
	logic reset_n;
	logic ce;
	bus_addr_t addr;
	bus_data_t wdata;
	logic wr;
	bus_data_t rdata;
	wire sd_dat;
	logic sd_dat3;
	logic sd_cmd;
	logic sd_clk;
	logic uart_txd;
	bus_data_t leds;

	// one entry per golden line
	byte op_q[$];
	bus_data_t ofs_q[$];
	bus_data_t dat_q[$];
	bus_data_t exp_q[$];

	int cycle = 0;
	int last_wr_edge;
	int sck_rises;
	int error_count;
	int limit;
	bus_data_t spi_tx;

	floppy_io UUT (
		.clk(clk),
		.reset_n(reset_n),
		.ce(ce),
		.addr(addr),
		.wdata(wdata),
		.wr(wr),
		.rdata(rdata),
		.sd_dat(sd_dat),
		.sd_dat3(sd_dat3),
		.sd_cmd(sd_cmd),
		.sd_clk(sd_clk),
		.uart_txd(uart_txd),
		.leds(leds)
	);

	// card loopback, miso follows mosi
	assign sd_dat = sd_cmd;

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// edge index, read only at falling edges or later
	always @(posedge clk) cycle <= cycle + 1;

	// mosi holds the written byte msb first at each rising sck edge
	always @(posedge sd_clk) begin
		if (sck_rises < 8) begin
			check_bit($sformatf("sd_cmd bit %0d", 7 - sck_rises), sd_cmd, spi_tx[7 - sck_rises]);
		end
		sck_rises <= sck_rises + 1;
	end

	//////////////////////////////
	// checks
	//////////////////////////////

	task automatic abort_run(input string what);
		error_count++;
		$display("%s", what);
		$display("sim failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_data(input string name, input bus_data_t got, input bus_data_t exp);
		if (got !== exp) begin
			error_count++;
			$display("ERROR %s expected %h got %h at cycle %0d", name, exp, got, cycle);
			$display("sim failed");
			$fatal(1, "first mismatch");
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			error_count++;
			$display("ERROR %s expected %h got %h at cycle %0d", name, exp, got, cycle);
			$display("sim failed");
			$fatal(1, "first mismatch");
		end
	endtask

	//////////////////////////////
	// bus tasks
	//////////////////////////////

	function automatic bus_addr_t port_addr(input bus_data_t ofs);
		bus_addr_t base;
		base = `IO_BASE;
		return {base[15:8], ofs};
	endfunction

	// all tasks start and end 10 ns after a rising edge
	task automatic bus_write(input bus_data_t ofs, input bus_data_t data, input logic en);
		addr = port_addr(ofs);
		wdata = data;
		wr = 1'b1;
		ce = en;
		@(posedge clk);
		#drive_skew;
		wr = 1'b0;
		ce = 1'b1;
		last_wr_edge = cycle;
		sck_rises = 0;
		if (ofs == SPDR && en) begin
			spi_tx = data;
		end
	endtask

	task automatic bus_read(input bus_data_t ofs, input bus_data_t exp);
		addr = port_addr(ofs);
		wr = 1'b0;
		@(negedge clk);
		check_data($sformatf("rdata[%h]", ofs), rdata, exp);
		if (ofs == LED) begin
			check_data("leds", leds, exp);
		end
		if (ofs == MMCA) begin
			check_bit("sd_dat3", sd_dat3, exp[0]);
		end
		@(posedge clk);
		#drive_skew;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#drive_skew;
		end
	endtask

	// falling edge just after rising edge number target
	task automatic wait_to_negedge(input int target);
		@(negedge clk);
		while (cycle < target) @(negedge clk);
	endtask

	// frame timed from the load edge of the preceding TXD write
	task automatic uart_frame(input bus_data_t frame, input bus_data_t intruder);
		int start;
		int j;
		logic exp_bit;
		start = last_wr_edge;
		addr = port_addr(CTL);
		for (j = 0; j < 10; j++) begin
			wait_to_negedge(start + `BAUD_DIV * j + `BAUD_DIV / 2);
			if (j == 0) begin
				exp_bit = 1'b0;
			end else if (j == 9) begin
				exp_bit = 1'b1;
			end else begin
				exp_bit = frame[j - 1];
			end
			check_bit($sformatf("uart_txd bit %0d", j), uart_txd, exp_bit);
			check_bit("ctl uart busy", rdata[0], 1'b1);
			if (j == 3) begin
				// second byte lands mid frame
				@(posedge clk);
				#drive_skew;
				bus_write(TXD, intruder, 1'b1);
				addr = port_addr(CTL);
			end
		end
		wait_to_negedge(start + 10 * `BAUD_DIV);
		check_bit("ctl uart busy", rdata[0], 1'b0);
		check_bit("uart_txd", uart_txd, 1'b1);
		@(posedge clk);
		#drive_skew;
	endtask

	task automatic spi_poll(input bus_data_t ofs, input bus_data_t mask, input bus_data_t rises);
		addr = port_addr(ofs);
		@(negedge clk);
		while ((rdata & mask) != 8'h00) @(negedge clk);
		check_data("sd_clk rising edges", bus_data_t'(sck_rises), rises);
		check_bit("sd_clk", sd_clk, 1'b0);
		@(posedge clk);
		#drive_skew;
	endtask

	//////////////////////////////
	// golden file
	//////////////////////////////

	task automatic load_golden();
		int fd;
		int n;
		string line;
		byte op;
		bus_data_t a;
		bus_data_t b;
		bus_data_t c;
		fd = $fopen("dv/floppy_io_golden.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open dv/floppy_io_golden.txt");
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line[0] == "#") begin
				continue;
			end
			n = $sscanf(line, "%c %h %h %h", op, a, b, c);
			if (n != 4) begin
				abort_run({"malformed line in golden file: ", line});
			end
			op_q.push_back(op);
			ofs_q.push_back(a);
			dat_q.push_back(b);
			exp_q.push_back(c);
		end
		$fclose(fd);
		if (op_q.size() == 0) begin
			abort_run("golden file holds no operations");
		end
	endtask

	// reset, one cycle per line, every wait, frames and transfers, plus margin
	function automatic int budget_cycles();
		int total;
		total = 8 + 200 + op_q.size();
		foreach (op_q[i]) begin
			case (op_q[i])
				"D": total += dat_q[i];
				"U": total += 10 * `BAUD_DIV + 2;
				"P": total += 16 * `SPI_DIV + 2;
				default: total += 1;
			endcase
		end
		return total;
	endfunction

	task automatic run_ops();
		foreach (op_q[i]) begin
			case (op_q[i])
				"W": bus_write(ofs_q[i], dat_q[i], 1'b1);
				"N": bus_write(ofs_q[i], dat_q[i], 1'b0);
				"R": bus_read(ofs_q[i], exp_q[i]);
				"D": wait_cycles(dat_q[i]);
				"U": uart_frame(dat_q[i], exp_q[i]);
				"P": spi_poll(ofs_q[i], dat_q[i], exp_q[i]);
				default: abort_run($sformatf("unknown op %c in golden entry %0d", op_q[i], i));
			endcase
		end
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin
		reset_n = 1'b0;
		ce = 1'b1;
		addr = '0;
		wdata = '0;
		wr = 1'b0;
		error_count = 0;
		sck_rises = 0;
		last_wr_edge = 0;
		limit = 0;
		spi_tx = '0;
		// timer waits in the golden file assume 20 clocks per tick
		if (`TICK_DIV != 20) begin
			abort_run("golden timer waits need a TICK_DIV of 20");
		end
		load_golden();
		limit = budget_cycles();
		repeat (8) @(posedge clk);
		#drive_skew;
		reset_n = 1'b1;
		run_ops();
		if (error_count == 0) begin
			$display("sim passed");
			$finish;
		end else begin
			$display("sim failed");
			$fatal(1, "checks reported mismatches");
		end
	end

	initial begin
		wait (limit > 0);
		repeat (limit) @(posedge clk);
		abort_run($sformatf("timeout, the run did not finish within %0d cycles", limit));
	end

endmodule

//--- sources.f
+incdir+source
source/bus_pkg.sv
source/port_map_pkg.sv
source/io_bus_if.sv
source/io_port_decode.sv
source/tick_timer.sv
source/uart_tx_fsm.sv
source/spi_shifter.sv
source/floppy_io.sv
dv/floppy_io_tb.sv

//--- dv/floppy_io_golden.txt
# columns: op, port offset, data, expected (hex); D waits data cycles
# U frame byte data with expected written mid frame; P poll until data bits clear, expected sck rises
R 00 00 01
R 10 00 00
R 02 00 00
R 06 00 00
R 07 00 00
R 08 00 00
R 03 00 ff
R ff 00 ff
N 10 55 00
R 10 00 00
W 10 3c 00
R 10 00 3c
W 00 00 00
R 00 00 00
W 00 01 00
R 00 00 01
W 07 05 00
W 08 09 00
D 00 13 00
R 07 00 04
R 08 00 08
D 00 13 00
R 07 00 03
R 08 00 07
D 00 4e 00
R 07 00 00
R 08 00 03
D 00 c8 00
R 07 00 00
R 08 00 00
W 04 a5 00
U 04 a5 3c
R 06 00 00
W 01 c3 00
P 02 01 08
R 01 00 c3
R 02 00 00
W 01 5a 00
P 02 01 08
R 01 00 5a
